// ==== compile.f ====
motor_monit_pkg.sv
rev_period_meter.sv
speed_window.sv
motor_health.sv
motor_monit.sv
motor_monit_properties.sv
tb_motor_monit.sv

// ==== motor_health.sv ====
// Turns the stream of good and bad revolutions into the motor state and fault outputs
module motor_health #(
	parameter int P_GOOD_REVS = 6,
	parameter int P_BAD_REVS  = 200
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_cal_mode,
	input  logic                       i_measure_mode,
	input  motor_monit_pkg::rev_meas_t i_meas,
	input  logic                       i_in_window,
	output logic                       o_motor_state,
	output logic                       o_motor_fault,
	output logic                       o_opto_err
);
	localparam int GOOD_W = $clog2(P_GOOD_REVS + 1);
	localparam int BAD_W  = $clog2(P_BAD_REVS + 1);
	localparam logic [GOOD_W-1:0] GOOD_LIMIT = GOOD_W'(P_GOOD_REVS);
	localparam logic [BAD_W-1:0]  BAD_LIMIT  = BAD_W'(P_BAD_REVS);

	logic [GOOD_W-1:0] r_good_cnt;
	logic [BAD_W-1:0]  r_bad_cnt;
	logic              w_good_run;
	logic              w_bad_run;
	logic              r_fault;
	logic              r_state;
	logic              r_opto_err;

	assign w_good_run = (r_good_cnt >= GOOD_LIMIT);
	assign w_bad_run  = (r_bad_cnt >= BAD_LIMIT);

	// ----------------------------------------------------------------------
	// Revolution run counters
	// ----------------------------------------------------------------------

	// A full good run holds through bad revolutions until a fault restarts it.
	// A stall always breaks the run
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_good_cnt <= '0;
		end else if (i_meas.stall) begin
			r_good_cnt <= '0;
		end else if (i_meas.valid) begin
			if (w_good_run) begin
				if (r_fault)
					r_good_cnt <= '0;
			end else if (i_in_window) begin
				r_good_cnt <= r_good_cnt + 1'b1;
			end else begin
				r_good_cnt <= '0;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_bad_cnt <= '0;
		else if (i_meas.valid) begin
			if (i_in_window)
				r_bad_cnt <= '0;
			else if (!w_bad_run)
				r_bad_cnt <= r_bad_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// Fault latch and motor state
	// ----------------------------------------------------------------------

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_fault    <= 1'b0;
			r_opto_err <= 1'b0;
		end else begin
			r_opto_err <= i_meas.stall;
			if (w_bad_run || i_meas.stall)
				r_fault <= 1'b1;
			else if (w_good_run)
				r_fault <= 1'b0;
		end
	end

	// Calibration wins over a fault
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_state <= 1'b0;
		else if (i_cal_mode)
			r_state <= 1'b1;
		else if (r_fault)
			r_state <= 1'b0;
		else if (w_good_run)
			r_state <= 1'b1;
	end

	assign o_motor_state = r_state & i_measure_mode;
	assign o_motor_fault = r_fault;
	assign o_opto_err    = r_opto_err;

endmodule

// ==== motor_monit.sv ====
// Top level of the motor spin monitor, joining period meter, speed window and health logic
module motor_monit #(
	parameter int P_SLOTS_PER_REV = 179,
	parameter int P_BASE_PERIOD   = 1_666_667,
	parameter int P_STALL_LIMIT   = 10_000_000,
	parameter int P_GOOD_REVS     = 6,
	parameter int P_BAD_REVS      = 200
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_cal_mode,
	input  motor_monit_pkg::freq_mode_e i_freq_mode,
	input  logic                        i_measure_mode,
	input  logic                        i_opto_switch,
	output logic                        o_motor_state,
	output logic                        o_motor_fault,
	output logic                        o_opto_err
);
	import motor_monit_pkg::*;

	rev_meas_t w_meas;
	logic      w_in_window;

	rev_period_meter #(
		.P_SLOTS_PER_REV (P_SLOTS_PER_REV),
		.P_STALL_LIMIT   (P_STALL_LIMIT)
	) u_meter (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_cal_mode    (i_cal_mode),
		.i_opto_switch (i_opto_switch),
		.o_meas        (w_meas)
	);

	speed_window #(
		.P_BASE_PERIOD (P_BASE_PERIOD)
	) u_window (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_freq_mode (i_freq_mode),
		.i_meas      (w_meas),
		.o_in_window (w_in_window)
	);

	motor_health #(
		.P_GOOD_REVS (P_GOOD_REVS),
		.P_BAD_REVS  (P_BAD_REVS)
	) u_health (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_cal_mode     (i_cal_mode),
		.i_measure_mode (i_measure_mode),
		.i_meas         (w_meas),
		.i_in_window    (w_in_window),
		.o_motor_state  (o_motor_state),
		.o_motor_fault  (o_motor_fault),
		.o_opto_err     (o_opto_err)
	);

endmodule

// ==== motor_monit_pkg.sv ====
// Shared types and window constants of the motor spin monitor, imported by each of its blocks
package motor_monit_pkg;

	// ----------------------------------------------------------------------
	// Frequency mode and revolution measurement
	// ----------------------------------------------------------------------

	// Code 3 is not named and keeps the current window
	typedef enum logic [1:0] {
		FREQ_30HZ = 2'd0,
		FREQ_15HZ = 2'd1,
		FREQ_50HZ = 2'd2
	} freq_mode_e;

	localparam int PERIOD_W = 24;

	typedef struct packed {
		logic                valid;
		logic                stall;
		logic [PERIOD_W-1:0] period;
	} rev_meas_t;

	// ----------------------------------------------------------------------
	// Speed window
	// ----------------------------------------------------------------------

	// Nominal period of each mode in tenths of the 30 Hz base
	localparam int MODE_DEN    = 10;
	localparam int MODE_NUM_30 = 10;
	localparam int MODE_NUM_15 = 20;
	localparam int MODE_NUM_50 = 6;

	// Bounds in tenths of nominal, both exclusive
	localparam int WIN_DEN    = 10;
	localparam int WIN_LO_NUM = 9;
	localparam int WIN_HI_NUM = 11;

	function automatic logic [PERIOD_W-1:0] win_bound(
		input longint base,
		input int     mode_num,
		input int     win_num
	);
		longint prod;
		prod = base * mode_num * win_num;
		return PERIOD_W'(prod / (MODE_DEN * WIN_DEN));
	endfunction

endpackage

// ==== motor_monit_properties.sv ====
// Concurrent output checks of the motor spin monitor, bound into every motor_monit instance
module motor_monit_properties (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cal_mode,
	input logic i_measure_mode,
	input logic i_motor_state,
	input logic i_motor_fault,
	input logic i_opto_err
);
	timeunit 1ns;
	timeprecision 1ps;

	// Failure tallies, one per assertion
	int n_fail_rst   = 0;
	int n_fail_gate  = 0;
	int n_fail_fault = 0;
	int n_fail_opto  = 0;

	// All outputs quiet through and just after reset
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_rst_n |=> (!i_motor_state && !i_motor_fault && !i_opto_err))
	else begin
		$error("outputs not low after reset");
		n_fail_rst++;
	end

	// State is gated by measure mode
	a_state_gated: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!i_measure_mode && !i_cal_mode) |-> !i_motor_state)
	else begin
		$error("motor state high with measure mode low");
		n_fail_gate++;
	end

	a_fault_clears_state: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_motor_fault && !i_cal_mode) |=> !i_motor_state)
	else begin
		$error("motor state still high a cycle after a fault");
		n_fail_fault++;
	end

	a_opto_err_fault: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_opto_err |=> i_motor_fault)
	else begin
		$error("opto error without a motor fault on the next cycle");
		n_fail_opto++;
	end

endmodule

bind motor_monit motor_monit_properties u_props (
	.i_clk          (i_clk),
	.i_rst_n        (i_rst_n),
	.i_cal_mode     (i_cal_mode),
	.i_measure_mode (i_measure_mode),
	.i_motor_state  (o_motor_state),
	.i_motor_fault  (o_motor_fault),
	.i_opto_err     (o_opto_err)
);

// ==== rev_period_meter.sv ====
// Opto slot counter that measures each revolution period and flags a stalled wheel
module rev_period_meter #(
	parameter int P_SLOTS_PER_REV = 179,
	parameter int P_STALL_LIMIT   = 10_000_000
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  logic                       i_cal_mode,
	input  logic                       i_opto_switch,
	output motor_monit_pkg::rev_meas_t o_meas
);
	import motor_monit_pkg::*;

	localparam int SLOT_W = (P_SLOTS_PER_REV > 1) ? $clog2(P_SLOTS_PER_REV) : 1;
	localparam logic [SLOT_W-1:0]   LAST_SLOT = SLOT_W'(P_SLOTS_PER_REV - 1);
	localparam logic [PERIOD_W-1:0] STALL_CNT = PERIOD_W'(P_STALL_LIMIT);

	logic                r_sync1;
	logic                r_sync2;
	logic                r_sync_d;
	logic                w_rise;
	logic                w_rev_done;
	logic [SLOT_W-1:0]   r_slot_cnt;
	logic [PERIOD_W-1:0] r_period_cnt;
	logic [PERIOD_W-1:0] r_period;
	logic                r_valid;
	logic                r_stall;

	// ----------------------------------------------------------------------
	// Switch synchroniser and rising edge
	// ----------------------------------------------------------------------

	// Idle level is high so calibration and reset never make an edge
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_sync1  <= 1'b1;
			r_sync2  <= 1'b1;
			r_sync_d <= 1'b1;
		end else if (i_cal_mode) begin
			r_sync1  <= 1'b1;
			r_sync2  <= 1'b1;
			r_sync_d <= 1'b1;
		end else begin
			r_sync1  <= i_opto_switch;
			r_sync2  <= r_sync1;
			r_sync_d <= r_sync2;
		end
	end

	assign w_rise     = r_sync2 & ~r_sync_d;
	assign w_rev_done = w_rise && (r_slot_cnt == LAST_SLOT) && !i_cal_mode;

	// ----------------------------------------------------------------------
	// Slot and period counters
	// ----------------------------------------------------------------------

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_slot_cnt   <= '0;
			r_period_cnt <= '0;
			r_valid      <= 1'b0;
			r_stall      <= 1'b0;
		end else if (i_cal_mode) begin
			r_slot_cnt   <= '0;
			r_period_cnt <= '0;
			r_valid      <= 1'b0;
			r_stall      <= 1'b0;
		end else begin
			r_valid <= w_rev_done;
			if (w_rev_done) begin
				r_slot_cnt   <= '0;
				r_period_cnt <= '0;
				r_stall      <= 1'b0;
			end else begin
				if (w_rise)
					r_slot_cnt <= r_slot_cnt + 1'b1;
				// Saturate so a dead wheel never wraps back into the window
				if (r_period_cnt != '1)
					r_period_cnt <= r_period_cnt + 1'b1;
				if (r_period_cnt >= STALL_CNT)
					r_stall <= 1'b1;
			end
		end
	end

	// Count includes the strobe cycle itself
	always_ff @(posedge i_clk) begin
		if (w_rev_done)
			r_period <= (r_period_cnt == '1) ? r_period_cnt : r_period_cnt + 1'b1;
	end

	assign o_meas = '{valid: r_valid, stall: r_stall, period: r_period};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the motor monitor testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_motor_monit -f compile.f

output=$(./obj_dir/Vtb_motor_monit +verilator+error+limit+100 2>&1) || true
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== speed_window.sv ====
// Holds the period window of the selected frequency mode and classifies each revolution
module speed_window #(
	parameter int P_BASE_PERIOD = 1_666_667
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  motor_monit_pkg::freq_mode_e i_freq_mode,
	input  motor_monit_pkg::rev_meas_t  i_meas,
	output logic                        o_in_window
);
	import motor_monit_pkg::*;

	localparam logic [PERIOD_W-1:0] LO_30 = win_bound(P_BASE_PERIOD, MODE_NUM_30, WIN_LO_NUM);
	localparam logic [PERIOD_W-1:0] HI_30 = win_bound(P_BASE_PERIOD, MODE_NUM_30, WIN_HI_NUM);
	localparam logic [PERIOD_W-1:0] LO_15 = win_bound(P_BASE_PERIOD, MODE_NUM_15, WIN_LO_NUM);
	localparam logic [PERIOD_W-1:0] HI_15 = win_bound(P_BASE_PERIOD, MODE_NUM_15, WIN_HI_NUM);
	localparam logic [PERIOD_W-1:0] LO_50 = win_bound(P_BASE_PERIOD, MODE_NUM_50, WIN_LO_NUM);
	localparam logic [PERIOD_W-1:0] HI_50 = win_bound(P_BASE_PERIOD, MODE_NUM_50, WIN_HI_NUM);

	logic [PERIOD_W-1:0] r_lo;
	logic [PERIOD_W-1:0] r_hi;

	// Out of reset the 30 Hz window applies
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_lo <= LO_30;
			r_hi <= HI_30;
		end else begin
			case (i_freq_mode)
				FREQ_30HZ: begin
					r_lo <= LO_30;
					r_hi <= HI_30;
				end
				FREQ_15HZ: begin
					r_lo <= LO_15;
					r_hi <= HI_15;
				end
				FREQ_50HZ: begin
					r_lo <= LO_50;
					r_hi <= HI_50;
				end
				default: begin
					r_lo <= r_lo;
					r_hi <= r_hi;
				end
			endcase
		end
	end

	// Strict on both sides, a period on a bound is a bad revolution
	assign o_in_window = i_meas.valid && (i_meas.period > r_lo) && (i_meas.period < r_hi);

endmodule

// ==== tb_motor_monit.sv ====
// Testbench for the motor spin monitor, spins a model code wheel through speed, mode and stall tests
module tb_motor_monit;
	timeunit 1ns;
	timeprecision 1ps;

	import motor_monit_pkg::*;

	localparam int SLOTS          = 4;
	localparam int BASE_PERIOD    = 1000;
	localparam int STALL_LIMIT    = 5000;
	localparam int GOOD_REVS      = 6;
	localparam int BAD_REVS       = 3;
	localparam int TIMEOUT_CYCLES = 150_000;

	// Nominal period of each mode in tenths of the base period
	localparam int NUM_30 = 10;
	localparam int NUM_15 = 20;
	localparam int NUM_50 = 6;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_cal_mode;
	freq_mode_e i_freq_mode;
	logic       i_measure_mode;
	logic       i_opto_switch;
	logic       o_motor_state;
	logic       o_motor_fault;
	logic       o_opto_err;

	integer seed;
	int     n_err;
	int     n_pass;
	int     n_fail;
	int     n_assert;
	int     test_err;
	int     cycle_cnt;
	int     wait_cnt;
	bit     exp_ok;

	motor_monit #(
		.P_SLOTS_PER_REV (SLOTS),
		.P_BASE_PERIOD   (BASE_PERIOD),
		.P_STALL_LIMIT   (STALL_LIMIT),
		.P_GOOD_REVS     (GOOD_REVS),
		.P_BAD_REVS      (BAD_REVS)
	) u_dut (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_cal_mode     (i_cal_mode),
		.i_freq_mode    (i_freq_mode),
		.i_measure_mode (i_measure_mode),
		.i_opto_switch  (i_opto_switch),
		.o_motor_state  (o_motor_state),
		.o_motor_fault  (o_motor_fault),
		.o_opto_err     (o_opto_err)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	// Window is 9/10 to 11/10 of nominal, both ends excluded
	function automatic bit rev_good(input int mode_num, input int rev_len);
		int lo;
		int hi;
		lo = BASE_PERIOD * mode_num * 9 / 100;
		hi = BASE_PERIOD * mode_num * 11 / 100;
		return (rev_len > lo) && (rev_len < hi);
	endfunction

	task automatic check_value(input string name, input logic exp, input logic act);
		assert (exp === act)
		else begin
			$display("[ERROR] %s expected %0b actual %0b", name, exp, act);
			n_err++;
		end
	endtask

	task automatic start_test();
		test_err = n_err;
	endtask

	task automatic finish_test(input string name);
		if (n_err == test_err) begin
			n_pass++;
			$display("test %-18s ok", name);
		end else begin
			n_fail++;
			$display("test %-18s fail", name);
		end
	endtask

	// One slot of the wheel, high for the first half
	task automatic drive_slot(input int len);
		int i;
		i_opto_switch = 1'b1;
		for (i = 0; i < len / 2; i++)
			@(negedge i_clk);
		i_opto_switch = 1'b0;
		for (i = len / 2; i < len; i++)
			@(negedge i_clk);
	endtask

	// Jitter lands on the last slot so the revolution is off by up to 3 cycles
	task automatic spin_revs(input int n_revs, input int rev_len, input bit jitter);
		int r;
		int s;
		int jit;
		int slot_len;
		slot_len = rev_len / SLOTS;
		for (r = 0; r < n_revs; r++) begin
			jit = jitter ? ($random(seed) % 4) : 0;
			for (s = 0; s < SLOTS - 1; s++)
				drive_slot(slot_len);
			drive_slot(rev_len - (SLOTS - 1) * slot_len + jit);
		end
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		seed           = 60746;
		n_err          = 0;
		n_pass         = 0;
		n_fail         = 0;
		i_rst_n        = 1'b0;
		i_cal_mode     = 1'b0;
		i_freq_mode    = FREQ_30HZ;
		i_measure_mode = 1'b1;
		i_opto_switch  = 1'b0;
		repeat (3) @(negedge i_clk);
		i_rst_n = 1'b1;

		// ------------------------------------------------------------------
		// Directed tests
		// ------------------------------------------------------------------

		start_test();
		spin_revs(GOOD_REVS + 2, 1000, 1'b1);
		exp_ok = rev_good(NUM_30, 1000);
		check_value("nominal_speed state", exp_ok, o_motor_state);
		check_value("nominal_speed fault", !exp_ok, o_motor_fault);
		i_measure_mode = 1'b0;
		@(negedge i_clk);
		check_value("nominal_speed gated", 1'b0, o_motor_state);
		i_measure_mode = 1'b1;
		finish_test("nominal_speed");

		start_test();
		i_freq_mode = FREQ_15HZ;
		spin_revs(BAD_REVS + 2, 1000, 1'b1);
		exp_ok = rev_good(NUM_15, 1000);
		check_value("wrong_mode fault", !exp_ok, o_motor_fault);
		check_value("wrong_mode state", exp_ok, o_motor_state);
		finish_test("wrong_mode");

		start_test();
		spin_revs(GOOD_REVS + 3, 2000, 1'b1);
		exp_ok = rev_good(NUM_15, 2000);
		check_value("recovery fault", !exp_ok, o_motor_fault);
		check_value("recovery state", exp_ok, o_motor_state);
		finish_test("recovery");

		start_test();
		i_freq_mode = FREQ_50HZ;
		spin_revs(GOOD_REVS, 600, 1'b1);
		exp_ok = rev_good(NUM_50, 600);
		check_value("window_edge 600 state", exp_ok, o_motor_state);
		check_value("window_edge 600 fault", !exp_ok, o_motor_fault);
		spin_revs(BAD_REVS + 2, 660, 1'b0);
		exp_ok = rev_good(NUM_50, 660);
		check_value("window_edge 660 fault", !exp_ok, o_motor_fault);
		check_value("window_edge 660 state", exp_ok, o_motor_state);
		finish_test("window_edge_50hz");

		start_test();
		// Healthy wheel first so only the stall can raise the fault
		spin_revs(GOOD_REVS + 2, 600, 1'b1);
		check_value("stall recovered fault", 1'b0, o_motor_fault);
		wait_cnt = 0;
		while (!o_opto_err && wait_cnt < STALL_LIMIT + 2 * BASE_PERIOD) begin
			@(negedge i_clk);
			wait_cnt++;
		end
		check_value("stall opto_err", 1'b1, o_opto_err);
		check_value("stall fault", 1'b1, o_motor_fault);
		i_cal_mode = 1'b1;
		repeat (3) @(negedge i_clk);
		check_value("stall cal state", 1'b1, o_motor_state);
		i_cal_mode = 1'b0;
		finish_test("stall");

		n_assert = u_dut.u_props.n_fail_rst + u_dut.u_props.n_fail_gate
			+ u_dut.u_props.n_fail_fault + u_dut.u_props.n_fail_opto;
		$display("tests %0d passed %0d failed %0d errors %0d assertion failures %0d",
			n_pass + n_fail, n_pass, n_fail, n_err, n_assert);
		if (n_err == 0 && n_fail == 0 && n_assert == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
